/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sata_link_tx
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_TEXT  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "Simulation PASS" || \
		(echo "Simulation FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
verilog/sata_pkg.sv
verilog/sata_crc.sv
verilog/sata_scrambler.sv
verilog/sata_frame_buffer.sv
verilog/sata_link_write.sv
verilog/sata_link_tx.sv
sim/sata_link_tx_asserts.sv
sim/tb_sata_link_tx.sv

/* sim/sata_link_stim.txt */
// Control word: size[31:20] is_device[19:16] r_rdy delay[15:8] stall[7:4] flags[3:0]
// Flags: bit0 answer R_ERR, bit1 X_RDY collision, bit2 sync escape. Payload words follow
00400200
00000001 12345678 DEADBEEF A5A5A5A5
00000000
00500311
FFFFFFFF 00000000 0F0F0F0F 80000001 13579BDF
00300102
CAFEBABE 00C0FFEE 11223344
00310112
76543210 FEDCBA98 AAAA5555
00600104
01010101 02020202 03030303 04040404 05050505 06060606
00210010
BEEFCAFE 0000FFFF
// End of frames
FFFFFFFF

/* sim/sata_link_tx_asserts.sv */
module sata_link_tx_asserts (
  input logic        clk,
  input logic        rst,
  input logic [31:0] tx_dout,
  input logic        tx_is_k,
  input logic        phy_ready,
  input logic        send_sync_escape,
  input logic        write_finished
);

  logic is_prim;

  assign is_prim = (tx_dout == sata_pkg::PRIM_SYNC) || (tx_dout == sata_pkg::PRIM_X_RDY) ||
                   (tx_dout == sata_pkg::PRIM_SOF) || (tx_dout == sata_pkg::PRIM_EOF) ||
                   (tx_dout == sata_pkg::PRIM_WTRM);

  k_matches_prim: assert property (@(posedge clk) disable iff (rst)
    tx_is_k == is_prim)
    else $error("tx_is_k does not match a primitive on tx_dout");

  finished_single: assert property (@(posedge clk) disable iff (rst)
    write_finished |=> !write_finished)
    else $error("write_finished high for two cycles");

  // Escape overrides the stall
  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (!phy_ready && !send_sync_escape) |=> $stable(tx_dout))
    else $error("tx_dout changed while phy_ready was low");

endmodule

/* sim/tb_sata_link_tx.sv */
module tb_sata_link_tx;

  localparam int ADDR_WIDTH = 11;

  logic                clk;
  logic                rst;
  logic                write_start;
  logic [ADDR_WIDTH:0] write_size;
  logic [31:0]         write_data;
  logic                phy_ready;
  logic                is_device;
  logic                send_sync_escape;
  logic                detect_x_rdy;
  logic                detect_r_rdy;
  logic                detect_r_ok;
  logic                detect_r_err;
  logic                write_strobe;
  logic [31:0]         tx_dout;
  logic                tx_is_k;
  logic                write_finished;
  logic                xmit_error;
  logic                wsize_z_error;
  logic                idle;

  logic [31:0] stim [0:255];
  logic [31:0] payload [$];
  logic [31:0] exp_q [$];
  logic [31:0] got [$];
  logic [31:0] last_k;
  logic        stall_mode;
  logic        fin_err;
  int          strobe_cnt;
  int          fin_cnt;
  int          xrdy_cnt;
  int          backoff_cnt;
  int          eof_cnt;
  int          wtrm_cnt;
  longint      limit;
  bit          limit_ready;

  sata_link_tx #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_sata_link_tx (.*);

  bind sata_link_tx sata_link_tx_asserts i_asserts (
    .clk              (clk),
    .rst              (rst),
    .tx_dout          (tx_dout),
    .tx_is_k          (tx_is_k),
    .phy_ready        (phy_ready),
    .send_sync_escape (send_sync_escape),
    .write_finished   (write_finished)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
    if (actual !== expected) begin
      $display("** Error at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Advance one cycle and drive inputs just after the edge
  task automatic step();
    @(posedge clk);
    #2;
    phy_ready  = stall_mode ? ($urandom % 4 != 0) : 1'b1;
    write_data = (strobe_cnt < payload.size()) ? payload[strobe_cnt] : 32'h0;
  endtask

  // Expected frame words from the CRC and scrambler definitions
  task automatic build_expected();
    logic [31:0] c;
    logic [15:0] s;
    logic [15:0] lo;
    logic [31:0] w;
    bit          fb;
    c = sata_pkg::CRC_INIT;
    foreach (payload[i]) begin
      for (int b = 31; b >= 0; b--) begin
        fb = c[31] ^ payload[i][b];
        c  = (c << 1) ^ (fb ? 32'h04C1_1DB7 : 32'h0);
      end
    end
    s = sata_pkg::SCR_SEED;
    exp_q.delete();
    for (int i = 0; i <= payload.size(); i++) begin
      lo = s;
      for (int j = 0; j < 16; j++) begin
        s = {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
      end
      w = (i < payload.size()) ? payload[i] : c;
      exp_q.push_back(w ^ {s, lo});
      for (int j = 0; j < 16; j++) begin
        s = {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
      end
    end
  endtask

  // Far-side view of the link with one word per ready cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (write_strobe) begin
        strobe_cnt++;
      end
      if (xmit_error && !write_finished) begin
        compare(32'(write_finished), 32'd1, "xmit_error without write_finished");
      end
      if (write_finished) begin
        fin_cnt++;
        fin_err = xmit_error;
      end
      if (phy_ready) begin
        if (tx_is_k) begin
          if (tx_dout == sata_pkg::PRIM_X_RDY) xrdy_cnt++;
          if (tx_dout == sata_pkg::PRIM_SYNC && last_k == sata_pkg::PRIM_X_RDY) backoff_cnt++;
          if (tx_dout == sata_pkg::PRIM_SOF) got.delete();
          if (tx_dout == sata_pkg::PRIM_EOF) eof_cnt++;
          if (tx_dout == sata_pkg::PRIM_WTRM) wtrm_cnt++;
          last_k = tx_dout;
        end
        else begin
          got.push_back(tx_dout);
        end
      end
    end
  end

  task automatic run_frame(input logic [31:0] ctrl, input int base);
    int size;
    int x0;
    int n0;
    bit err;
    size = int'(ctrl[31:20]);
    err  = ctrl[0];
    payload.delete();
    for (int i = 0; i < size; i++) begin
      payload.push_back(stim[base + 1 + i]);
    end
    build_expected();
    got.delete();
    strobe_cnt  = 0;
    x0          = xrdy_cnt;
    is_device   = (ctrl[19:16] != 0);
    stall_mode  = (ctrl[7:4] != 0) && !ctrl[2];
    write_size  = (ADDR_WIDTH + 1)'(size);
    write_start = 1'b1;
    step();
    write_start = 1'b0;
    if (size == 0) begin
      compare(32'(wsize_z_error), 32'd1, "wsize_z_error after zero size");
      repeat (10) step();
      compare(xrdy_cnt, x0, "X_RDY sent for zero size");
      compare(strobe_cnt, 0, "write_strobe for zero size");
      compare(32'(idle), 32'd1, "idle after zero size");
      return;
    end
    while (xrdy_cnt == x0) step();
    if (ctrl[1]) begin
      detect_x_rdy = 1'b1;
      if (!is_device) begin
        n0 = backoff_cnt;
        while (backoff_cnt == n0) step();
        detect_x_rdy = 1'b0;
        x0 = xrdy_cnt;
        while (xrdy_cnt == x0) step();
      end
    end
    repeat (int'(ctrl[15:8])) step();
    detect_r_rdy = 1'b1;
    if (ctrl[2]) begin
      while (got.size() < 2) step();
      send_sync_escape = 1'b1;
      step();
      send_sync_escape = 1'b0;
      detect_r_rdy     = 1'b0;
      compare(tx_dout, sata_pkg::PRIM_SYNC, "SYNC after escape");
      compare(32'(idle), 32'd1, "idle after escape");
      return;
    end
    n0 = eof_cnt;
    while (eof_cnt == n0) step();
    detect_r_rdy = 1'b0;
    detect_x_rdy = 1'b0;
    compare(got.size(), exp_q.size(), "frame word count");
    foreach (exp_q[i]) begin
      compare(got[i], exp_q[i], $sformatf("frame word %0d", i));
    end
    n0 = wtrm_cnt;
    while (wtrm_cnt == n0) step();
    detect_r_ok  = !err;
    detect_r_err = err;
    n0 = fin_cnt;
    while (fin_cnt == n0) step();
    detect_r_ok  = 1'b0;
    detect_r_err = 1'b0;
    compare(32'(fin_err), 32'(err), "xmit_error with write_finished");
    compare(strobe_cnt, size, "write_strobe count");
    step();
    compare(tx_dout, sata_pkg::PRIM_SYNC, "SYNC after frame");
  endtask

  initial begin
    wait (limit_ready);
    #(limit);
    $display("Timeout: the frames did not finish within %0d time units", limit);
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    int idx;
    void'($urandom(32'hb7a3_2baf));
    rst              = 1'b1;
    write_start      = 1'b0;
    write_size       = '0;
    write_data       = '0;
    phy_ready        = 1'b1;
    is_device        = 1'b0;
    send_sync_escape = 1'b0;
    detect_x_rdy     = 1'b0;
    detect_r_rdy     = 1'b0;
    detect_r_ok      = 1'b0;
    detect_r_err     = 1'b0;
    stall_mode       = 1'b0;
    last_k           = '0;
    $readmemh("sim/sata_link_stim.txt", stim);
    limit = 0;
    idx   = 0;
    while (stim[idx] !== 32'hFFFF_FFFF) begin
      limit = limit + (longint'(stim[idx][31:20]) + 40) * 4 * 40;
      idx   = idx + 1 + int'(stim[idx][31:20]);
    end
    limit_ready = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    compare(tx_dout, sata_pkg::PRIM_SYNC, "tx_dout after reset");
    compare(32'(tx_is_k), 32'd1, "tx_is_k after reset");
    compare(32'(idle), 32'd1, "idle after reset");
    compare({write_strobe, write_finished, xmit_error, wsize_z_error}, 4'b0,
            "pulses after reset");
    idx = 0;
    while (stim[idx] !== 32'hFFFF_FFFF) begin
      run_frame(stim[idx], idx);
      idx = idx + 1 + int'(stim[idx][31:20]);
      repeat (3) step();
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* verilog/sata_crc.sv */
module sata_crc (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic        en,
  input  logic [31:0] din,
  output logic [31:0] crc
);

  // Serial CRC unrolled over one word, data MSB first
  function automatic logic [31:0] crc_word(
    input logic [31:0] c,
    input logic [31:0] d
  );
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 31; i >= 0; i--) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0};
      if (fb) begin
        r = r ^ sata_pkg::CRC_POLY;
      end
    end
    return r;
  endfunction

  // Seeded at the start of every frame
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      crc <= sata_pkg::CRC_INIT;
    end
    else if (en) begin
      crc <= crc_word(crc, din);
    end
  end

endmodule

/* verilog/sata_frame_buffer.sv */
module sata_frame_buffer #(
  parameter int ADDR_WIDTH = 11
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [31:0]           wdata,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [31:0]           rdata
);

  logic [31:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* verilog/sata_link_tx.sv */
module sata_link_tx #(
  parameter int ADDR_WIDTH = 11
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                write_start,
  input  logic [ADDR_WIDTH:0] write_size,
  input  logic [31:0]         write_data,
  input  logic                phy_ready,
  input  logic                is_device,
  input  logic                send_sync_escape,
  input  logic                detect_x_rdy,
  input  logic                detect_r_rdy,
  input  logic                detect_r_ok,
  input  logic                detect_r_err,
  output logic                write_strobe,
  output logic [31:0]         tx_dout,
  output logic                tx_is_k,
  output logic                write_finished,
  output logic                xmit_error,
  output logic                wsize_z_error,
  output logic                idle
);

  logic                  crc_en;
  logic                  crc_clear;
  logic                  scr_en;
  logic                  scr_clear;
  logic                  scr_din_sel;
  logic                  buf_we;
  logic [ADDR_WIDTH-1:0] buf_waddr;
  logic [ADDR_WIDTH-1:0] buf_raddr;
  logic [31:0]           buf_rdata;
  logic [31:0]           crc;
  logic [31:0]           scr_din;
  logic [31:0]           scr_dout;

  // Payload words first, then the finished CRC
  assign scr_din = scr_din_sel ? crc : write_data;

  sata_link_write #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_link_write (
    .clk              (clk),
    .rst              (rst),
    .write_start      (write_start),
    .write_size       (write_size),
    .phy_ready        (phy_ready),
    .is_device        (is_device),
    .send_sync_escape (send_sync_escape),
    .detect_x_rdy     (detect_x_rdy),
    .detect_r_rdy     (detect_r_rdy),
    .detect_r_ok      (detect_r_ok),
    .detect_r_err     (detect_r_err),
    .write_strobe     (write_strobe),
    .tx_dout          (tx_dout),
    .tx_is_k          (tx_is_k),
    .write_finished   (write_finished),
    .xmit_error       (xmit_error),
    .wsize_z_error    (wsize_z_error),
    .idle             (idle),
    .crc_en           (crc_en),
    .crc_clear        (crc_clear),
    .scr_en           (scr_en),
    .scr_clear        (scr_clear),
    .scr_din_sel      (scr_din_sel),
    .buf_we           (buf_we),
    .buf_waddr        (buf_waddr),
    .buf_raddr        (buf_raddr),
    .buf_rdata        (buf_rdata)
  );

  sata_frame_buffer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_frame_buffer (
    .clk   (clk),
    .we    (buf_we),
    .waddr (buf_waddr),
    .wdata (scr_dout),
    .raddr (buf_raddr),
    .rdata (buf_rdata)
  );

  // CRC runs over the raw payload as it is strobed out of the supplier
  sata_crc i_crc (
    .clk   (clk),
    .rst   (rst),
    .clear (crc_clear),
    .en    (crc_en),
    .din   (write_data),
    .crc   (crc)
  );

  sata_scrambler i_scrambler (
    .clk   (clk),
    .rst   (rst),
    .clear (scr_clear),
    .en    (scr_en),
    .din   (scr_din),
    .dout  (scr_dout)
  );

endmodule

/* verilog/sata_link_write.sv */
module sata_link_write #(
  parameter int ADDR_WIDTH = 11
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write_start,
  input  logic [ADDR_WIDTH:0]   write_size,
  input  logic                  phy_ready,
  input  logic                  is_device,
  input  logic                  send_sync_escape,
  input  logic                  detect_x_rdy,
  input  logic                  detect_r_rdy,
  input  logic                  detect_r_ok,
  input  logic                  detect_r_err,
  output logic                  write_strobe,
  output logic [31:0]           tx_dout,
  output logic                  tx_is_k,
  output logic                  write_finished,
  output logic                  xmit_error,
  output logic                  wsize_z_error,
  output logic                  idle,
  output logic                  crc_en,
  output logic                  crc_clear,
  output logic                  scr_en,
  output logic                  scr_clear,
  output logic                  scr_din_sel,
  output logic                  buf_we,
  output logic [ADDR_WIDTH-1:0] buf_waddr,
  output logic [ADDR_WIDTH-1:0] buf_raddr,
  input  logic [31:0]           buf_rdata
);

  sata_pkg::fill_state_t fill_state;
  sata_pkg::tx_state_t   tx_state;

  logic [ADDR_WIDTH:0] fill_size;
  logic [ADDR_WIDTH:0] strobe_cnt;
  logic [ADDR_WIDTH:0] rd_cnt;
  logic [ADDR_WIDTH:0] rd_last;
  logic                frame_ready;
  logic                frame_done;
  logic                rd_advance;

  // Frame is complete once the CRC write has gone through
  assign frame_ready = (fill_state == sata_pkg::FILL_WAIT) && !buf_we;
  assign frame_done  = phy_ready && (tx_state == sata_pkg::TX_WTRM) &&
                       (detect_r_ok || detect_r_err);

  // Payload plus CRC
  assign rd_last = fill_size + 1'b1;

  assign crc_en      = write_strobe;
  assign crc_clear   = (fill_state == sata_pkg::FILL_IDLE);
  assign scr_clear   = (fill_state == sata_pkg::FILL_IDLE);
  assign scr_din_sel = (fill_state == sata_pkg::FILL_CRC);
  assign scr_en      = write_strobe || scr_din_sel;

  assign idle = (tx_state == sata_pkg::TX_IDLE) && (fill_state == sata_pkg::FILL_IDLE);

  // Read address runs one step ahead, so buf_rdata always holds word rd_cnt
  assign rd_advance = phy_ready && ((tx_state == sata_pkg::TX_SOF) ||
                      ((tx_state == sata_pkg::TX_DATA) && (rd_cnt != rd_last)));
  assign buf_raddr  = rd_advance ? rd_cnt[ADDR_WIDTH-1:0] + 1'b1 : rd_cnt[ADDR_WIDTH-1:0];

  // Fill sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_state    <= sata_pkg::FILL_IDLE;
      fill_size     <= '0;
      strobe_cnt    <= '0;
      write_strobe  <= 1'b0;
      wsize_z_error <= 1'b0;
      buf_we        <= 1'b0;
      buf_waddr     <= '0;
    end
    else begin
      wsize_z_error <= 1'b0;
      // Scrambler output is registered, the write trails scr_en by one cycle
      buf_we        <= scr_en;
      if (buf_we) begin
        buf_waddr <= buf_waddr + 1'b1;
      end
      case (fill_state)
        sata_pkg::FILL_IDLE: begin
          buf_waddr <= '0;
          if (write_start) begin
            if (write_size == '0) begin
              wsize_z_error <= 1'b1;
            end
            else begin
              fill_size    <= write_size;
              strobe_cnt   <= 1;
              write_strobe <= 1'b1;
              fill_state   <= sata_pkg::FILL_DATA;
            end
          end
        end
        sata_pkg::FILL_DATA: begin
          if (strobe_cnt == fill_size) begin
            write_strobe <= 1'b0;
            fill_state   <= sata_pkg::FILL_CRC;
          end
          else begin
            strobe_cnt <= strobe_cnt + 1'b1;
          end
        end
        sata_pkg::FILL_CRC: begin
          // CRC register now covers the last payload word
          fill_state <= sata_pkg::FILL_WAIT;
        end
        sata_pkg::FILL_WAIT: begin
          if (frame_done) begin
            fill_state <= sata_pkg::FILL_IDLE;
          end
        end
        default: begin
          fill_state <= sata_pkg::FILL_IDLE;
        end
      endcase
      if (send_sync_escape) begin
        fill_state   <= sata_pkg::FILL_IDLE;
        write_strobe <= 1'b0;
      end
    end
  end

  // Transmit protocol machine, frozen whenever the PHY is not ready
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_state       <= sata_pkg::TX_IDLE;
      tx_dout        <= sata_pkg::PRIM_SYNC;
      tx_is_k        <= 1'b1;
      rd_cnt         <= '0;
      write_finished <= 1'b0;
      xmit_error     <= 1'b0;
    end
    else begin
      write_finished <= 1'b0;
      xmit_error     <= 1'b0;
      if (phy_ready) begin
        case (tx_state)
          sata_pkg::TX_IDLE: begin
            rd_cnt  <= '0;
            tx_dout <= sata_pkg::PRIM_SYNC;
            tx_is_k <= 1'b1;
            if (frame_ready) begin
              tx_state <= sata_pkg::TX_XRDY;
              tx_dout  <= sata_pkg::PRIM_X_RDY;
            end
          end
          sata_pkg::TX_XRDY: begin
            if (!is_device && detect_x_rdy) begin
              // Collision, the device wins and we retry from SYNC
              tx_state <= sata_pkg::TX_IDLE;
              tx_dout  <= sata_pkg::PRIM_SYNC;
            end
            else if (detect_r_rdy) begin
              tx_state <= sata_pkg::TX_SOF;
              tx_dout  <= sata_pkg::PRIM_SOF;
            end
          end
          sata_pkg::TX_SOF: begin
            tx_dout  <= buf_rdata;
            tx_is_k  <= 1'b0;
            rd_cnt   <= rd_cnt + 1'b1;
            tx_state <= sata_pkg::TX_DATA;
          end
          sata_pkg::TX_DATA: begin
            if (rd_cnt == rd_last) begin
              tx_dout  <= sata_pkg::PRIM_EOF;
              tx_is_k  <= 1'b1;
              tx_state <= sata_pkg::TX_EOF;
            end
            else begin
              tx_dout <= buf_rdata;
              rd_cnt  <= rd_cnt + 1'b1;
            end
          end
          sata_pkg::TX_EOF: begin
            tx_dout  <= sata_pkg::PRIM_WTRM;
            tx_state <= sata_pkg::TX_WTRM;
          end
          sata_pkg::TX_WTRM: begin
            if (frame_done) begin
              write_finished <= 1'b1;
              xmit_error     <= detect_r_err;
              tx_dout        <= sata_pkg::PRIM_SYNC;
              tx_state       <= sata_pkg::TX_IDLE;
            end
          end
          default: begin
            tx_state <= sata_pkg::TX_IDLE;
          end
        endcase
      end
      if (send_sync_escape) begin
        tx_state <= sata_pkg::TX_IDLE;
        tx_dout  <= sata_pkg::PRIM_SYNC;
        tx_is_k  <= 1'b1;
        rd_cnt   <= '0;
      end
    end
  end

endmodule

/* verilog/sata_pkg.sv */
package sata_pkg;

  // Link primitives, always sent as K words
  localparam logic [31:0] PRIM_SYNC  = 32'hB5B5_957C;
  localparam logic [31:0] PRIM_X_RDY = 32'h5757_B57C;
  localparam logic [31:0] PRIM_SOF   = 32'h3737_B57C;
  localparam logic [31:0] PRIM_EOF   = 32'hD5D5_B57C;
  localparam logic [31:0] PRIM_WTRM  = 32'h5858_B57C;

  // CRC-32 seed and generator, MSB first, no final inversion
  localparam logic [31:0] CRC_INIT = 32'h5232_5032;
  localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

  // Scrambler LFSR x^16+x^15+x^13+x^4+1
  // Feedback taps on state bits 15, 14, 12 and 3
  localparam logic [15:0] SCR_SEED = 16'hFFFF;
  localparam logic [15:0] SCR_TAPS = 16'hD008;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_DATA,
    FILL_CRC,
    FILL_WAIT
  } fill_state_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_XRDY,
    TX_SOF,
    TX_DATA,
    TX_EOF,
    TX_WTRM
  } tx_state_t;

endpackage

/* verilog/sata_scrambler.sv */
module sata_scrambler (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear,
  input  logic        en,
  input  logic [31:0] din,
  output logic [31:0] dout
);

  logic [15:0] lfsr;
  logic [15:0] lfsr_mid;
  logic [15:0] lfsr_next;
  logic [31:0] mask;

  // Sixteen single-bit shifts, new bit enters at the bottom
  function automatic logic [15:0] lfsr_step16(input logic [15:0] s);
    logic [15:0] r;
    r = s;
    for (int i = 0; i < 16; i++) begin
      r = {r[14:0], ^(r & sata_pkg::SCR_TAPS)};
    end
    return r;
  endfunction

  assign lfsr_mid  = lfsr_step16(lfsr);
  assign lfsr_next = lfsr_step16(lfsr_mid);

  // Current state is the low half, the state 16 steps on is the high half
  assign mask = {lfsr_mid, lfsr};

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      lfsr <= sata_pkg::SCR_SEED;
    end
    else if (en) begin
      lfsr <= lfsr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      dout <= din ^ mask;
    end
  end

endmodule
